// ==== Bender.yml ====
package:
  name: fetch_predict

sources:
  - files:
      - logic/bp_pkg.sv
      - logic/table_clear_counter.sv
      - logic/fetch_ctrl.sv
      - logic/branch_predictor.sv
      - logic/pc_gen.sv
      - logic/fetch_predict_top.sv
  - target: simulation
    files:
      - tb/clk_gen.sv
      - tb/fetch_predict_asserts.sv
      - tb/tb_fetch_predict.sv

// ==== logic/bp_pkg.sv ====
package bp_pkg;

	// table geometry
	localparam int XLEN = 32;
	localparam int INDEX_BITS = 9;
	localparam int TABLE_DEPTH = 1 << INDEX_BITS;

	// instructions are word aligned, so the index starts at pc bit 2
	localparam int INDEX_LSB = 2;
	localparam int TAG_BITS = XLEN - INDEX_BITS - INDEX_LSB;

	localparam logic [XLEN-1:0] RESET_PC = '0;

	// major opcodes the predictor tells apart
	typedef enum logic [6:0] {
		OP_BRANCH = 7'b1100011,
		OP_OTHER  = 7'b0000000
	} opcode_t;

	// 2-bit saturating counter, msb set means predict taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} bht_state_t;

	// fetch controller
	typedef enum logic {
		ST_CLEAR = 1'b0,
		ST_RUN   = 1'b1
	} ctrl_state_t;

endpackage

// ==== logic/branch_predictor.sv ====
module branch_predictor
	import bp_pkg::*;
(
	input  logic                  CLK,
	input  logic                  clearing,
	input  logic [INDEX_BITS-1:0] clear_index,
	input  logic [XLEN-1:0]       pc,
	input  logic [XLEN-1:0]       inst,
	input  logic                  fetch,
	input  logic                  resolve,
	input  logic [XLEN-1:0]       res_pc,
	input  logic                  res_taken,
	output logic [XLEN-1:0]       next_pc,
	output logic                  pred_taken
);

	logic                valid_mem  [TABLE_DEPTH];
	logic [TAG_BITS-1:0] tag_mem    [TABLE_DEPTH];
	bht_state_t          bht_mem    [TABLE_DEPTH];
	logic [XLEN-1:0]     target_mem [TABLE_DEPTH];

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0]   tag;
	logic                  hit;
	logic                  counter_taken;
	opcode_t               op;
	logic [XLEN-1:0]       imm;
	logic [XLEN-1:0]       branch_target;
	logic                  alloc;

	logic [INDEX_BITS-1:0] res_index;
	logic [TAG_BITS-1:0]   res_tag;
	logic                  res_hit;
	logic                  train;
	bht_state_t            trained_state;

	// one step toward the resolved direction, saturating at both ends
	function automatic bht_state_t step_counter(input bht_state_t cur, input logic taken);
		bht_state_t nxt;
		nxt = cur;
		case (cur)
			STRONG_NT: nxt = taken ? WEAK_NT : STRONG_NT;
			WEAK_NT:   nxt = taken ? WEAK_T : STRONG_NT;
			WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
			STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
			default:   nxt = WEAK_T;
		endcase
		return nxt;
	endfunction

	// fetch side lookup
	assign index = pc[INDEX_LSB +: INDEX_BITS];
	assign tag   = pc[XLEN-1 -: TAG_BITS];
	assign hit   = valid_mem[index] && (tag_mem[index] == tag);

	assign counter_taken = bht_mem[index][1];

	assign op = (inst[6:0] == OP_BRANCH) ? OP_BRANCH : OP_OTHER;

	// B-type immediate, sign from inst[31]
	assign imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	assign branch_target = pc + imm;

	always_comb begin
		if (hit) begin
			pred_taken = counter_taken;
			next_pc    = counter_taken ? target_mem[index] : pc + XLEN'(4);
		end else if (op == OP_BRANCH) begin
			// first sighting of a branch goes taken
			pred_taken = 1'b1;
			next_pc    = branch_target;
		end else begin
			pred_taken = 1'b0;
			next_pc    = pc + XLEN'(4);
		end
	end

	assign alloc = fetch && !hit && (op == OP_BRANCH);

	// execute side training
	assign res_index = res_pc[INDEX_LSB +: INDEX_BITS];
	assign res_tag   = res_pc[XLEN-1 -: TAG_BITS];
	assign res_hit   = valid_mem[res_index] && (tag_mem[res_index] == res_tag);

	// an allocation to the same entry in this cycle takes precedence
	assign train = resolve && res_hit && !(alloc && (res_index == index));

	assign trained_state = step_counter(bht_mem[res_index], res_taken);

	always_ff @(posedge CLK) begin
		if (clearing) begin
			valid_mem[clear_index] <= 1'b0;
			bht_mem[clear_index]   <= WEAK_T;
		end else begin
			if (train) begin
				bht_mem[res_index] <= trained_state;
			end
			if (alloc) begin
				valid_mem[index]  <= 1'b1;
				tag_mem[index]    <= tag;
				bht_mem[index]    <= WEAK_T;
				target_mem[index] <= branch_target;
			end
		end
	end

endmodule

// ==== logic/fetch_ctrl.sv ====
module fetch_ctrl
	import bp_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,
	input  logic clear_done,
	output logic clearing,
	output logic ready
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= ST_CLEAR;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_CLEAR: begin
				// sweep ends with the last index, run from the next edge
				if (clear_done) begin
					state_next = ST_RUN;
				end
			end
			ST_RUN: begin
				state_next = ST_RUN;
			end
			default: begin
				state_next = ST_CLEAR;
			end
		endcase
	end

	assign clearing = (state == ST_CLEAR);
	assign ready    = (state == ST_RUN);

endmodule

// ==== logic/fetch_predict_top.sv ====
module fetch_predict_top
	import bp_pkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,
	input  logic            fetch,
	input  logic [XLEN-1:0] inst,
	input  logic            resolve,
	input  logic [XLEN-1:0] res_pc,
	input  logic            res_taken,
	input  logic            redirect,
	input  logic [XLEN-1:0] redirect_pc,
	output logic [XLEN-1:0] pc,
	output logic            pred_taken,
	output logic            ready
);

	logic                  clearing;
	logic                  clear_done;
	logic [INDEX_BITS-1:0] clear_index;
	logic [XLEN-1:0]       next_pc;

	logic fetch_en;
	logic resolve_en;
	logic redirect_en;

	// strobes only count once the table sweep is done
	assign fetch_en    = fetch && ready;
	assign resolve_en  = resolve && ready;
	assign redirect_en = redirect && ready;

	fetch_ctrl u_ctrl (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.clear_done (clear_done),
		.clearing   (clearing),
		.ready      (ready)
	);

	table_clear_counter u_clear (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.clearing    (clearing),
		.clear_index (clear_index),
		.clear_done  (clear_done)
	);

	branch_predictor u_pred (
		.CLK         (CLK),
		.clearing    (clearing),
		.clear_index (clear_index),
		.pc          (pc),
		.inst        (inst),
		.fetch       (fetch_en),
		.resolve     (resolve_en),
		.res_pc      (res_pc),
		.res_taken   (res_taken),
		.next_pc     (next_pc),
		.pred_taken  (pred_taken)
	);

	pc_gen u_pc (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.fetch       (fetch_en),
		.next_pc     (next_pc),
		.redirect    (redirect_en),
		.redirect_pc (redirect_pc),
		.pc          (pc)
	);

endmodule

// ==== logic/pc_gen.sv ====
module pc_gen
	import bp_pkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,
	input  logic            fetch,
	input  logic [XLEN-1:0] next_pc,
	input  logic            redirect,
	input  logic [XLEN-1:0] redirect_pc,
	output logic [XLEN-1:0] pc
);

	logic [XLEN-1:0] pc_q;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
		end else if (redirect) begin
			// execute stage correction beats the prediction
			pc_q <= redirect_pc;
		end else if (fetch) begin
			pc_q <= next_pc;
		end
	end

	assign pc = pc_q;

endmodule

// ==== logic/table_clear_counter.sv ====
module table_clear_counter
	import bp_pkg::*;
(
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  clearing,
	output logic [INDEX_BITS-1:0] clear_index,
	output logic                  clear_done
);

	localparam logic [INDEX_BITS-1:0] LAST_INDEX = INDEX_BITS'(TABLE_DEPTH - 1);

	logic [INDEX_BITS-1:0] index_q;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			index_q <= '0;
		end else if (clearing) begin
			// one entry per cycle, wraps back to zero after the last one
			if (index_q == LAST_INDEX) begin
				index_q <= '0;
			end else begin
				index_q <= index_q + 1'b1;
			end
		end else begin
			index_q <= '0;
		end
	end

	assign clear_index = index_q;
	assign clear_done  = clearing && (index_q == LAST_INDEX);

endmodule

// ==== tb/clk_gen.sv ====
module clk_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// reset released on the edge that ends the last reset cycle
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		rst_n <= 1'b1;
	end

endmodule

// ==== tb/fetch_predict_asserts.sv ====
module fetch_predict_asserts
	import bp_pkg::*;
(
	input logic            CLK,
	input logic            rst_n,
	input logic            fetch,
	input logic            redirect,
	input logic            ready,
	input logic            pred_taken,
	input logic            hit,
	input logic [XLEN-1:0] inst,
	input logic [XLEN-1:0] pc
);

	bit   pc_hold_failed    = 1'b0;
	bit   ready_drop_failed = 1'b0;
	bit   taken_failed      = 1'b0;
	logic any_failed;

	assign any_failed = pc_hold_failed || ready_drop_failed || taken_failed;

	// pc only moves on an accepted fetch or redirect
	property pc_holds;
		@(posedge CLK) disable iff (!rst_n)
		!(ready && (fetch || redirect)) |=> $stable(pc);
	endproperty

	property ready_stays;
		@(posedge CLK) disable iff (!rst_n)
		ready |=> ready;
	endproperty

	// a miss on a non-branch word always falls through
	property no_taken_on_plain_miss;
		@(posedge CLK) disable iff (!rst_n)
		(ready && (inst[6:0] != OP_BRANCH) && !hit) |-> !pred_taken;
	endproperty

	pc_hold_check: assert property (pc_holds) else begin
		pc_hold_failed = 1'b1;
		$error("pc changed in a cycle without fetch or redirect");
	end

	ready_check: assert property (ready_stays) else begin
		ready_drop_failed = 1'b1;
		$error("ready fell after it was high");
	end

	taken_check: assert property (no_taken_on_plain_miss) else begin
		taken_failed = 1'b1;
		$error("pred_taken high for a non-branch word without a tag hit");
	end

endmodule

bind fetch_predict_top fetch_predict_asserts u_asserts (
	.CLK        (CLK),
	.rst_n      (rst_n),
	.fetch      (fetch),
	.redirect   (redirect),
	.ready      (ready),
	.pred_taken (pred_taken),
	.hit        (u_pred.hit),
	.inst       (inst),
	.pc         (pc)
);

// ==== tb/tb_fetch_predict.sv ====
module tb_fetch_predict
	import bp_pkg::*;
;

	localparam int RESET_CYCLES = 8;
	localparam int SEED = 97721;

	typedef struct {
		logic            fetch;
		logic [XLEN-1:0] inst;
		logic            resolve;
		logic [XLEN-1:0] res_pc;
		logic            res_taken;
		logic            redirect;
		logic [XLEN-1:0] redirect_pc;
		logic [XLEN-1:0] exp_pc;
		logic            exp_taken;
	} step_t;

	logic            CLK;
	logic            rst_n;
	logic            fetch;
	logic [XLEN-1:0] inst;
	logic            resolve;
	logic [XLEN-1:0] res_pc;
	logic            res_taken;
	logic            redirect;
	logic [XLEN-1:0] redirect_pc;
	logic [XLEN-1:0] pc;
	logic            pred_taken;
	logic            ready;

	step_t steps[$];
	string where = "reset";
	int    cycles = 0;
	int    cycle_limit = 0;

	// reference copy of the predictor tables
	logic                m_valid  [TABLE_DEPTH];
	logic [TAG_BITS-1:0] m_tag    [TABLE_DEPTH];
	logic [1:0]          m_ctr    [TABLE_DEPTH];
	logic [XLEN-1:0]     m_target [TABLE_DEPTH];
	logic [XLEN-1:0]     m_pc;

	clk_gen #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clk (.CLK(CLK), .rst_n(rst_n));

	fetch_predict_top uut (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.fetch       (fetch),
		.inst        (inst),
		.resolve     (resolve),
		.res_pc      (res_pc),
		.res_taken   (res_taken),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.pred_taken  (pred_taken),
		.ready       (ready)
	);

	task automatic stop_on_failure();
		$display(">>> FAIL");
		$fatal(1, "run stopped at time %0t", $time);
	endtask

	task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: pc is %h, expected %h", $time, where, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_taken(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: pred_taken is %b, expected %b", $time, where, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: ready is %b, expected %b", $time, where, got, exp);
			stop_on_failure();
		end
	endtask

	function automatic int model_index(input logic [XLEN-1:0] a);
		return int'((a >> 2) & (TABLE_DEPTH - 1));
	endfunction

	function automatic logic [TAG_BITS-1:0] model_tag(input logic [XLEN-1:0] a);
		return TAG_BITS'(a >> (XLEN - TAG_BITS));
	endfunction

	// beq x1, x2 with the given byte offset
	function automatic logic [XLEN-1:0] branch_word(input int offset);
		logic [12:0] off;
		off = offset[12:0];
		return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic logic [XLEN-1:0] filler_word();
		logic [31:0] r;
		r = $urandom();
		return {r[31:7], 7'b0010011};
	endfunction

	// offset is the byte offset the branch word was built with
	task automatic add_step(input logic f, input logic [XLEN-1:0] word, input int offset,
		input logic r, input logic [XLEN-1:0] rpc, input logic rt,
		input logic d, input logic [XLEN-1:0] dpc);
		step_t           s;
		int              idx;
		int              ridx;
		logic            hit;
		logic            res_hit;
		logic            is_branch;
		logic            alloc;
		logic [XLEN-1:0] target;
		s = '{f, word, r, rpc, rt, d, dpc, m_pc, 1'b0};
		idx = model_index(m_pc);
		hit = m_valid[idx] && (m_tag[idx] == model_tag(m_pc));
		is_branch = (word[6:0] == OP_BRANCH);
		if (hit) begin
			s.exp_taken = (m_ctr[idx] >= WEAK_T);
			target = s.exp_taken ? m_target[idx] : m_pc + 4;
		end else if (is_branch) begin
			s.exp_taken = 1'b1;
			target = m_pc + XLEN'(offset);
		end else begin
			s.exp_taken = 1'b0;
			target = m_pc + 4;
		end
		alloc = f && !hit && is_branch;
		ridx = model_index(rpc);
		res_hit = m_valid[ridx] && (m_tag[ridx] == model_tag(rpc));
		// training uses the counter as it was before this edge
		if (r && res_hit && !(alloc && ridx == idx)) begin
			if (rt && m_ctr[ridx] != 2'b11) begin
				m_ctr[ridx] = m_ctr[ridx] + 2'd1;
			end else if (!rt && m_ctr[ridx] != 2'b00) begin
				m_ctr[ridx] = m_ctr[ridx] - 2'd1;
			end
		end
		if (alloc) begin
			m_valid[idx]  = 1'b1;
			m_tag[idx]    = model_tag(m_pc);
			m_ctr[idx]    = WEAK_T;
			m_target[idx] = target;
		end
		if (d) begin
			m_pc = dpc;
		end else if (f) begin
			m_pc = target;
		end
		steps.push_back(s);
	endtask

	task automatic fetch_word(input logic [XLEN-1:0] word);
		add_step(1'b1, word, 0, 1'b0, '0, 1'b0, 1'b0, '0);
	endtask

	task automatic fetch_branch(input int offset);
		add_step(1'b1, branch_word(offset), offset, 1'b0, '0, 1'b0, 1'b0, '0);
	endtask

	task automatic resolve_at(input logic [XLEN-1:0] a, input logic taken);
		add_step(1'b0, '0, 0, 1'b1, a, taken, 1'b0, '0);
	endtask

	task automatic redirect_to(input logic [XLEN-1:0] a);
		add_step(1'b0, '0, 0, 1'b0, '0, 1'b0, 1'b1, a);
	endtask

	task automatic build_table();
		for (int i = 0; i < TABLE_DEPTH; i++) begin
			m_valid[i] = 1'b0;
			m_tag[i]   = '0;
			m_ctr[i]   = WEAK_T;
			m_target[i] = '0;
		end
		m_pc = RESET_PC;
		repeat (4) fetch_word(filler_word());
		fetch_branch(64);
		fetch_word(filler_word());
		fetch_word(filler_word());
		fetch_branch(-32);
		// train the entry at 0x10 down, then back up
		redirect_to(32'h10);
		resolve_at(32'h10, 1'b0);
		resolve_at(32'h10, 1'b0);
		fetch_branch(64);
		resolve_at(32'h10, 1'b1);
		redirect_to(32'h10);
		add_step(1'b1, branch_word(64), 64, 1'b1, 32'h10, 1'b1, 1'b0, '0);
		redirect_to(32'h10);
		fetch_branch(64);
		// redirect beats a fetch in the same cycle
		add_step(1'b1, filler_word(), 0, 1'b0, '0, 1'b0, 1'b1, 32'h100);
		// 0x810 aliases 0x10 with another tag
		redirect_to(32'h810);
		fetch_branch(8);
		redirect_to(32'h10);
		fetch_word(filler_word());
		redirect_to(32'h810);
		fetch_word(filler_word());
		// allocation and training on one entry in one cycle
		redirect_to(32'h10);
		add_step(1'b1, branch_word(64), 64, 1'b1, 32'h810, 1'b0, 1'b0, '0);
		redirect_to(32'h10);
		fetch_word(filler_word());
		add_step(1'b0, '0, 0, 1'b0, '0, 1'b0, 1'b0, '0);
	endtask

	always @(posedge CLK) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the test table did not finish within %0d cycles", cycle_limit);
			stop_on_failure();
		end
	end

	always @(negedge CLK) begin
		if (uut.u_asserts.any_failed) begin
			$display("a bound assertion failed, see the message above");
			stop_on_failure();
		end
	end

	initial begin
		fetch       = 1'b0;
		inst        = '0;
		resolve     = 1'b0;
		res_pc      = '0;
		res_taken   = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		void'($urandom(SEED));
		build_table();
		cycle_limit = RESET_CYCLES + TABLE_DEPTH + steps.size() + 50;

		wait (rst_n === 1'b1);
		// strobes during the clear sweep must be ignored
		where = "clear sweep";
		for (int k = 1; k <= TABLE_DEPTH; k++) begin
			@(posedge CLK);
			fetch       <= (k < TABLE_DEPTH);
			inst        <= branch_word(64);
			redirect    <= (k < TABLE_DEPTH);
			redirect_pc <= 32'h400;
			@(negedge CLK);
			check_ready(ready, k == TABLE_DEPTH);
			check_pc(pc, RESET_PC);
		end

		foreach (steps[i]) begin
			@(posedge CLK);
			fetch       <= steps[i].fetch;
			inst        <= steps[i].inst;
			resolve     <= steps[i].resolve;
			res_pc      <= steps[i].res_pc;
			res_taken   <= steps[i].res_taken;
			redirect    <= steps[i].redirect;
			redirect_pc <= steps[i].redirect_pc;
			@(negedge CLK);
			where = $sformatf("step %0d", i);
			check_ready(ready, 1'b1);
			check_pc(pc, steps[i].exp_pc);
			check_taken(pred_taken, steps[i].exp_taken);
		end

		@(negedge CLK);
		if (uut.u_asserts.any_failed) begin
			$display("a bound assertion failed, see the message above");
			stop_on_failure();
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
logic/bp_pkg.sv
logic/table_clear_counter.sv
logic/fetch_ctrl.sv
logic/branch_predictor.sv
logic/pc_gen.sv
logic/fetch_predict_top.sv
tb/clk_gen.sv
tb/fetch_predict_asserts.sv
tb/tb_fetch_predict.sv
